//--- Makefile
# build and run the execution datapath testbench with Verilator

TOP = execDatapath_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f execDatapath.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "^Everything OK$$"

lint:
	verilator --lint-only --timing -Wall -f execDatapath.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- aluCore.sv
// 8-bit ALU: add with carry, AND, EOR, OR and right shift of A
// subtract arrives as an add of the inverted operand from the decoder
// halfCarry and overflow are only meaningful for the sum
`timescale 1ns/1ns

module aluCore import cpuPkg::*; (
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic       carryIn,
    input  aluFuncE    aluFunc,
    output logic [7:0] binSum,
    output logic       halfCarry,
    output logic       carryOut,
    output logic       overflow
);

    always_comb begin
        binSum    = 8'h00;
        halfCarry = 1'b0;
        carryOut  = 1'b0;
        overflow  = 1'b0;
        case (aluFunc)
            aluSum: begin
                // low nibble first so the half carry is available to BCD adjust
                {halfCarry, binSum[3:0]} = {1'b0, a[3:0]} + {1'b0, b[3:0]}
                                           + {4'b0000, carryIn};
                {carryOut, binSum[7:4]} = {1'b0, a[7:4]} + {1'b0, b[7:4]}
                                          + {4'b0000, halfCarry};
                // same-sign inputs giving a different-sign sum
                overflow = (a[7] == b[7]) && (binSum[7] != a[7]);
            end
            aluAnd: begin
                binSum = a & b;
            end
            aluEor: begin
                binSum = a ^ b;
            end
            aluOra: begin
                binSum = a | b;
            end
            aluLsr: begin
                // bit 0 falls out into the carry
                binSum   = {1'b0, a[7:1]};
                carryOut = a[0];
            end
            default: begin
                binSum = a;
            end
        endcase
    end

endmodule

//--- cpuPkg.sv
// types and constants shared by the execution datapath
// uop is a 5-bit code since its 17 values with nop do not fit in 4 bits
// status layout is NV-BDIZC, I and B always read 0 and bit 5 always reads 1
package cpuPkg;

    // micro-operations taken on the opValid strobe
    typedef enum logic [4:0] {
        uopNop,
        uopAdc,
        uopSbc,
        uopAnd,
        uopEor,
        uopOra,
        uopLsr,
        uopLda,
        uopLdr,
        uopTar,
        uopTra,
        uopInr,
        uopDer,
        uopSec,
        uopClc,
        uopSed,
        uopCld
    } uopE;

    // index register select, value 3 addresses no register
    typedef enum logic [1:0] {
        regX,
        regY,
        regS
    } regSelE;

    // function picked inside the ALU
    typedef enum logic [2:0] {
        aluSum,
        aluAnd,
        aluEor,
        aluOra,
        aluLsr
    } aluFuncE;

    // source of the byte that is written and reported
    typedef enum logic [2:0] {
        selAlu,
        selOperand,
        selIndexValue,
        selIndexNext,
        selStatus
    } resultSelE;

    localparam int numIndexRegs = 3;
    // X, Y, S in regSelE order
    localparam logic [7:0] indexResetValues [numIndexRegs] = '{8'h00, 8'h00, 8'hFF};

    localparam int statusC = 0;
    localparam int statusZ = 1;
    localparam int statusD = 3;
    localparam int statusV = 6;
    localparam int statusN = 7;
    localparam logic [7:0] statusResetValue = 8'h20;

endpackage

//--- decimalAdjust.sv
// BCD correction of the adder output
// results are only valid BCD when both inputs were valid BCD
// with decimalEn low the sum and carry pass through untouched
`timescale 1ns/1ns

module decimalAdjust (
    input  logic [7:0] binSum,
    input  logic       halfCarry,
    input  logic       carryOut,
    input  logic       subtract,
    input  logic       decimalEn,
    output logic [7:0] adjusted,
    output logic       adjCarry
);

    logic       lowFix;
    logic       highFix;
    logic [8:0] lowAdj;

    always_comb begin
        lowFix   = 1'b0;
        highFix  = 1'b0;
        lowAdj   = {1'b0, binSum};
        adjusted = binSum;
        adjCarry = carryOut;
        if (decimalEn && !subtract) begin
            // low digit over 9 or a nibble carry
            lowFix = (binSum[3:0] > 4'd9) || halfCarry;
            lowAdj = {1'b0, binSum} + (lowFix ? 9'h006 : 9'h000);
            // high digit checked after the low fix has rippled in
            highFix  = (lowAdj[8:4] > 5'd9) || carryOut;
            adjusted = lowAdj[7:0] + (highFix ? 8'h60 : 8'h00);
            adjCarry = highFix;
        end else if (decimalEn) begin
            // a missing carry out of a digit means that digit borrowed
            adjusted = binSum - (halfCarry ? 8'h00 : 8'h06) - (carryOut ? 8'h00 : 8'h60);
        end
    end

endmodule

//--- execChecker.sv
// watches the execution datapath and compares it against a reference model
// model state is advanced at the rising edge, outputs are compared at the falling edge
// state is compared every cycle after reset, result only while a pulse is due
// testName is written by the testbench before each test
`timescale 1ns/1ns

module execChecker import cpuPkg::*; (
    input  logic       phi2,
    input  logic       rstN,
    input  logic       opValid,
    input  uopE        uop,
    input  regSelE     regSel,
    input  logic [7:0] operand,
    input  logic [7:0] accum,
    input  logic [7:0] xValue,
    input  logic [7:0] yValue,
    input  logic [7:0] sValue,
    input  logic [7:0] status,
    input  logic [7:0] result,
    input  logic       resultValid,
    output int         checkCount,
    output int         errorCount
);

    typedef struct packed {
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] s;
        logic [7:0] p;
        logic [7:0] res;
    } modelT;

    string testName = "none";
    modelT model;
    logic  live;
    logic  pending;
    uopE   pendingUop;

    // applies one operation to the model, res holds the byte that gets reported
    function automatic modelT nextState(modelT m, uopE u, regSelE r, logic [7:0] d);
        modelT      n;
        logic [7:0] b;
        logic [7:0] idx;
        logic [8:0] sum;
        logic [8:0] fix;
        logic       half;
        logic       setNZ;
        n = m;
        setNZ = 1'b1;
        idx = (r == regX) ? m.x : ((r == regY) ? m.y : m.s);
        // subtract is A plus the one's complement plus carry
        b = (u == uopSbc) ? ~d : d;
        sum = {1'b0, m.a} + {1'b0, b} + {8'h00, m.p[statusC]};
        half = ({1'b0, m.a[3:0]} + {1'b0, b[3:0]} + {4'h0, m.p[statusC]}) > 5'd15;
        case (u)
            uopAdc, uopSbc: begin
                n.res = sum[7:0];
                n.p[statusC] = sum[8];
                // V from the binary sum in both modes
                n.p[statusV] = ((m.a ^ sum[7:0]) & (b ^ sum[7:0]) & 8'h80) != 8'h00;
                if (m.p[statusD] && (u == uopAdc)) begin
                    fix = {1'b0, sum[7:0]};
                    if ((fix[3:0] > 4'd9) || half) begin
                        fix = fix + 9'h006;
                    end
                    // high digit judged after the low correction
                    if ((fix[8:4] > 5'd9) || sum[8]) begin
                        fix = fix + 9'h060;
                        n.p[statusC] = 1'b1;
                    end else begin
                        n.p[statusC] = 1'b0;
                    end
                    n.res = fix[7:0];
                end else if (m.p[statusD]) begin
                    // a digit without carry out borrowed
                    if (!half) begin
                        n.res -= 8'h06;
                    end
                    if (!sum[8]) begin
                        n.res -= 8'h60;
                    end
                end
                n.a = n.res;
            end
            uopAnd: begin
                n.res = m.a & d;
                n.a = n.res;
            end
            uopEor: begin
                n.res = m.a ^ d;
                n.a = n.res;
            end
            uopOra: begin
                n.res = m.a | d;
                n.a = n.res;
            end
            uopLsr: begin
                n.p[statusC] = m.a[0];
                n.res = m.a >> 1;
                n.a = n.res;
            end
            uopLda: begin
                n.res = d;
                n.a = d;
            end
            uopTra: begin
                n.res = idx;
                n.a = idx;
            end
            uopLdr, uopTar, uopInr, uopDer: begin
                if (u == uopLdr) begin
                    n.res = d;
                end else if (u == uopTar) begin
                    n.res = m.a;
                end else if (u == uopInr) begin
                    n.res = idx + 8'd1;
                end else begin
                    n.res = idx - 8'd1;
                end
                if (r == regX) begin
                    n.x = n.res;
                end else if (r == regY) begin
                    n.y = n.res;
                end else begin
                    n.s = n.res;
                end
                // stack pointer writes leave the flags alone
                setNZ = (r != regS);
            end
            uopSec, uopClc, uopSed, uopCld: begin
                setNZ = 1'b0;
                if (u == uopSec) begin
                    n.p[statusC] = 1'b1;
                end else if (u == uopClc) begin
                    n.p[statusC] = 1'b0;
                end else if (u == uopSed) begin
                    n.p[statusD] = 1'b1;
                end else begin
                    n.p[statusD] = 1'b0;
                end
                n.res = n.p;
            end
            default: begin
                setNZ = 1'b0;
            end
        endcase
        if (setNZ) begin
            n.p[statusN] = n.res[7];
            n.p[statusZ] = (n.res == 8'h00);
        end
        return n;
    endfunction

    task automatic compareByte(string what, logic [7:0] expected, logic [7:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("[FAIL] %s: %s expected %02h actual %02h", testName, what, expected, actual);
        end
    endtask

    initial begin
        checkCount = 0;
        errorCount = 0;
        live = 1'b0;
        pending = 1'b0;
        pendingUop = uopNop;
    end

    // inputs change on the falling edge, so they are settled here
    always @(posedge phi2) begin
        live = rstN;
        if (!rstN) begin
            model = '{a: 8'h00, x: 8'h00, y: 8'h00, s: 8'hFF, p: 8'h20, res: 8'h00};
            pending = 1'b0;
        end else if (opValid && (uop != uopNop)) begin
            model = nextState(model, uop, regSel, operand);
            pending = 1'b1;
            pendingUop = uop;
        end else begin
            pending = 1'b0;
        end
    end

    always @(negedge phi2) begin
        if (live) begin
            if (pending && !resultValid) begin
                errorCount++;
                $display("%s: no result pulse after a %s operation", testName, pendingUop.name());
            end else if (!pending && resultValid) begin
                errorCount++;
                $display("%s: result pulse without an operation before it", testName);
            end else if (pending) begin
                compareByte("result", model.res, result);
            end
            compareByte("accum", model.a, accum);
            compareByte("X", model.x, xValue);
            compareByte("Y", model.y, yValue);
            compareByte("S", model.s, sValue);
            compareByte("status", model.p, status);
        end
    end

endmodule

//--- execDatapath.f
cpuPkg.sv
opDecoder.sv
indexRegister.sv
aluCore.sv
decimalAdjust.sv
resultWriteback.sv
execDatapath.sv
execChecker.sv
execDatapath_tb.sv

//--- execDatapath.sv
// 6502-style execution datapath without fetch, addressing or bus
// one micro-operation per phi2 cycle, result reported one cycle later
// no back-pressure, opValid is a single-cycle strobe
`timescale 1ns/1ns

module execDatapath import cpuPkg::*; (
    input  logic       phi2,
    input  logic       rstN,
    input  logic       opValid,
    input  uopE        uop,
    input  regSelE     regSel,
    input  logic [7:0] operand,
    output logic [7:0] accum,
    output logic [7:0] xValue,
    output logic [7:0] yValue,
    output logic [7:0] sValue,
    output logic [7:0] status,
    output logic [7:0] result,
    output logic       resultValid
);

    aluFuncE                 aluFunc;
    logic [7:0]              aluB;
    logic                    carryIn;
    logic                    subtract;
    logic                    decimalEn;
    logic [numIndexRegs-1:0] loadEn;
    logic [numIndexRegs-1:0] incEn;
    logic [numIndexRegs-1:0] decEn;
    logic [7:0]              loadData;
    logic                    accWrite;
    resultSelE               resultSel;
    logic                    nzUpdate;
    logic [1:0]              cvUpdate;
    logic                    flagSetC;
    logic                    flagClrC;
    logic                    flagSetD;
    logic                    flagClrD;
    logic                    opDone;
    logic [7:0]              indexValues [numIndexRegs];
    logic [7:0]              indexNext [numIndexRegs];
    logic [7:0]              binSum;
    logic                    halfCarry;
    logic                    carryOut;
    logic                    overflow;
    logic [7:0]              adjusted;
    logic                    adjCarry;

    opDecoder opDecoder_i (
        .opValid(opValid), .uop(uop), .regSel(regSel), .operand(operand),
        .accum(accum), .carryFlag(status[statusC]), .decimalFlag(status[statusD]),
        .aluFunc(aluFunc), .aluB(aluB), .carryIn(carryIn), .subtract(subtract),
        .decimalEn(decimalEn), .loadEn(loadEn), .incEn(incEn), .decEn(decEn),
        .loadData(loadData), .accWrite(accWrite), .resultSel(resultSel),
        .nzUpdate(nzUpdate), .cvUpdate(cvUpdate), .flagSetC(flagSetC),
        .flagClrC(flagClrC), .flagSetD(flagSetD), .flagClrD(flagClrD), .opDone(opDone)
    );

    // X, Y and S differ only in their reset value
    for (genvar i = 0; i < numIndexRegs; i++) begin : gIndex
        indexRegister #(.resetValue(indexResetValues[i])) indexRegister_i (
            .phi2(phi2), .rstN(rstN), .loadEn(loadEn[i]), .incEn(incEn[i]),
            .decEn(decEn[i]), .loadData(loadData),
            .value(indexValues[i]), .nextValue(indexNext[i])
        );
    end

    aluCore aluCore_i (
        .a(accum), .b(aluB), .carryIn(carryIn), .aluFunc(aluFunc),
        .binSum(binSum), .halfCarry(halfCarry), .carryOut(carryOut), .overflow(overflow)
    );

    decimalAdjust decimalAdjust_i (
        .binSum(binSum), .halfCarry(halfCarry), .carryOut(carryOut), .subtract(subtract),
        .decimalEn(decimalEn), .adjusted(adjusted), .adjCarry(adjCarry)
    );

    resultWriteback resultWriteback_i (
        .phi2(phi2), .rstN(rstN), .opDone(opDone), .accWrite(accWrite),
        .resultSel(resultSel), .nzUpdate(nzUpdate), .cvUpdate(cvUpdate),
        .flagSetC(flagSetC), .flagClrC(flagClrC), .flagSetD(flagSetD), .flagClrD(flagClrD),
        .adjusted(adjusted), .adjCarry(adjCarry), .overflow(overflow), .operand(operand),
        .indexValues(indexValues), .indexNext(indexNext), .regSel(regSel),
        .accum(accum), .status(status), .result(result), .resultValid(resultValid)
    );

    assign xValue = indexValues[regX];
    assign yValue = indexValues[regY];
    assign sValue = indexValues[regS];

endmodule

//--- execDatapath_tb.sv
// testbench for the execution datapath
// inputs change on the falling phi2 edge, execChecker does all comparing
// decimal operands are valid BCD in the directed decimal test only
// the run is bounded by a watchdog sized from the operation counts
`timescale 1ns/1ns

module execDatapath_tb import cpuPkg::*;;

    localparam int resetCycles   = 8;
    localparam int logicRounds   = 40;
    localparam int arithRounds   = 40;
    localparam int decimalRounds = 40;
    localparam int streamOps     = 2000;
    // every op slot counted, stream ops may be followed by one gap cycle
    localparam int totalOps = logicRounds * 2 + arithRounds * 3 + 16 + decimalRounds * 3 + 2
                              + 3 * 11 + streamOps * 2 + 6 * 4 + 4;
    localparam int watchdogNs = totalOps * 4 * 2 + resetCycles * 4;

    logic        phi2;
    logic        rstN;
    logic        opValid;
    uopE         uop;
    regSelE      regSel;
    logic [7:0]  operand;
    logic [7:0]  accum;
    logic [7:0]  xValue;
    logic [7:0]  yValue;
    logic [7:0]  sValue;
    logic [7:0]  status;
    logic [7:0]  result;
    logic        resultValid;
    int          checks;
    int          errors;
    int          checksAtStart;
    int          errorsAtStart;
    string       currentTest;

    execDatapath execDatapath_i (
        .phi2(phi2), .rstN(rstN), .opValid(opValid), .uop(uop), .regSel(regSel),
        .operand(operand), .accum(accum), .xValue(xValue), .yValue(yValue),
        .sValue(sValue), .status(status), .result(result), .resultValid(resultValid)
    );

    execChecker execChecker_i (
        .phi2(phi2), .rstN(rstN), .opValid(opValid), .uop(uop), .regSel(regSel),
        .operand(operand), .accum(accum), .xValue(xValue), .yValue(yValue),
        .sValue(sValue), .status(status), .result(result), .resultValid(resultValid),
        .checkCount(checks), .errorCount(errors)
    );

    always #2 phi2 = ~phi2;

    task automatic issueOp(uopE u, regSelE r, logic [7:0] d);
        @(negedge phi2);
        opValid = 1'b1;
        uop = u;
        regSel = r;
        operand = d;
    endtask

    task automatic idleCycle();
        @(negedge phi2);
        opValid = 1'b0;
        uop = uopNop;
    endtask

    task automatic beginTest(string name);
        currentTest = name;
        execChecker_i.testName = name;
        checksAtStart = checks;
        errorsAtStart = errors;
    endtask

    // lets the last pulse drain, counts are read at the rising edge
    // after the last falling-edge compare
    task automatic endTest();
        repeat (4) idleCycle();
        @(posedge phi2);
        $display("test %s done: %0d checks, %0d errors", currentTest,
                 checks - checksAtStart, errors - errorsAtStart);
    endtask

    function automatic logic [7:0] randomBcd();
        logic [3:0] hi;
        logic [3:0] lo;
        hi = 4'($urandom_range(9, 0));
        lo = 4'($urandom_range(9, 0));
        return {hi, lo};
    endfunction

    initial begin
        #(watchdogNs);
        $display("watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

    initial begin
        uopE    pick;
        regSelE r;
        void'($urandom(32'h1b97a9c6));
        phi2 = 1'b0;
        rstN = 1'b0;
        opValid = 1'b0;
        uop = uopNop;
        regSel = regX;
        operand = 8'h00;
        repeat (resetCycles) @(negedge phi2);
        rstN = 1'b1;

        beginTest("reset");
        endTest();

        beginTest("logic");
        for (int i = 0; i < logicRounds; i++) begin
            issueOp(uopLda, regX, 8'($urandom));
            pick = uopE'($urandom_range(int'(uopLsr), int'(uopAnd)));
            issueOp(pick, regX, 8'($urandom));
        end
        endTest();

        beginTest("binary");
        issueOp(uopCld, regX, 8'h00);
        // signed overflow both ways and carry wrap at zero
        issueOp(uopLda, regX, 8'h7F);
        issueOp(uopClc, regX, 8'h00);
        issueOp(uopAdc, regX, 8'h01);
        issueOp(uopLda, regX, 8'h80);
        issueOp(uopSec, regX, 8'h00);
        issueOp(uopSbc, regX, 8'h01);
        issueOp(uopLda, regX, 8'hFF);
        issueOp(uopClc, regX, 8'h00);
        issueOp(uopAdc, regX, 8'h01);
        issueOp(uopLda, regX, 8'h00);
        issueOp(uopSec, regX, 8'h00);
        issueOp(uopSbc, regX, 8'h01);
        issueOp(uopLda, regX, 8'h80);
        issueOp(uopClc, regX, 8'h00);
        issueOp(uopAdc, regX, 8'h80);
        for (int i = 0; i < arithRounds; i++) begin
            issueOp(uopLda, regX, 8'($urandom));
            issueOp(($urandom_range(1, 0) != 0) ? uopSec : uopClc, regX, 8'h00);
            issueOp(($urandom_range(1, 0) != 0) ? uopAdc : uopSbc, regX, 8'($urandom));
        end
        endTest();

        beginTest("decimal");
        issueOp(uopSed, regX, 8'h00);
        for (int i = 0; i < decimalRounds; i++) begin
            issueOp(uopLda, regX, randomBcd());
            issueOp(($urandom_range(1, 0) != 0) ? uopSec : uopClc, regX, 8'h00);
            issueOp(($urandom_range(1, 0) != 0) ? uopAdc : uopSbc, regX, randomBcd());
        end
        issueOp(uopCld, regX, 8'h00);
        endTest();

        beginTest("index");
        for (int i = 0; i < 3; i++) begin
            r = regSelE'(i);
            issueOp(uopLdr, r, 8'($urandom));
            issueOp(uopTra, r, 8'h00);
            issueOp(uopLda, r, 8'($urandom));
            issueOp(uopTar, r, 8'h00);
            issueOp(uopTra, r, 8'h00);
            issueOp(uopInr, r, 8'h00);
            issueOp(uopDer, r, 8'h00);
            // wrap through FF and 00
            issueOp(uopLdr, r, 8'hFF);
            issueOp(uopInr, r, 8'h00);
            issueOp(uopLdr, r, 8'h00);
            issueOp(uopDer, r, 8'h00);
        end
        endTest();

        beginTest("stream");
        for (int i = 0; i < streamOps; i++) begin
            pick = uopE'($urandom_range(int'(uopCld), int'(uopNop)));
            r = regSelE'($urandom_range(2, 0));
            issueOp(pick, r, 8'($urandom));
            if ($urandom_range(3, 0) == 0) begin
                idleCycle();
            end
        end
        endTest();

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- indexRegister.sv
// one 8-bit index register cell, used for X, Y and S
// increment and decrement wrap around, strobes must not overlap
`timescale 1ns/1ns

module indexRegister #(
    parameter logic [7:0] resetValue = 8'h00
) (
    input  logic       phi2,
    input  logic       rstN,
    input  logic       loadEn,
    input  logic       incEn,
    input  logic       decEn,
    input  logic [7:0] loadData,
    output logic [7:0] value,
    output logic [7:0] nextValue
);

    // next value is visible before the edge so writeback can report it
    always_comb begin
        if (loadEn) begin
            nextValue = loadData;
        end else if (incEn) begin
            nextValue = value + 8'd1;
        end else if (decEn) begin
            nextValue = value - 8'd1;
        end else begin
            nextValue = value;
        end
    end

    always_ff @(posedge phi2) begin
        if (!rstN) begin
            value <= resetValue;
        end else begin
            value <= nextValue;
        end
    end

    // decoder and cell agree on a single action per edge
    strobeExclusive: assert property (
        @(posedge phi2) disable iff (!rstN) $onehot0({loadEn, incEn, decEn})
    ) else $error("indexRegister: overlapping strobes");

endmodule

//--- opDecoder.sv
// turns one micro-operation into datapath controls, purely combinational
// every strobe is qualified by opValid, controls that only steer muxes are not
// index operations aimed at S leave N and Z alone
`timescale 1ns/1ns

module opDecoder import cpuPkg::*; (
    input  logic                    opValid,
    input  uopE                     uop,
    input  regSelE                  regSel,
    input  logic [7:0]              operand,
    input  logic [7:0]              accum,
    input  logic                    carryFlag,
    input  logic                    decimalFlag,
    output aluFuncE                 aluFunc,
    output logic [7:0]              aluB,
    output logic                    carryIn,
    output logic                    subtract,
    output logic                    decimalEn,
    output logic [numIndexRegs-1:0] loadEn,
    output logic [numIndexRegs-1:0] incEn,
    output logic [numIndexRegs-1:0] decEn,
    output logic [7:0]              loadData,
    output logic                    accWrite,
    output resultSelE               resultSel,
    output logic                    nzUpdate,
    output logic [1:0]              cvUpdate,
    output logic                    flagSetC,
    output logic                    flagClrC,
    output logic                    flagSetD,
    output logic                    flagClrD,
    output logic                    opDone
);

    logic isArith;
    logic isLogic;
    logic indexWrite;

    assign isArith    = (uop == uopAdc) || (uop == uopSbc);
    assign isLogic    = uop inside {uopAnd, uopEor, uopOra, uopLsr};
    assign indexWrite = uop inside {uopLdr, uopTar, uopInr, uopDer};

    // sbc is an add of the inverted operand, carry acts as not-borrow
    assign subtract  = (uop == uopSbc);
    assign aluB      = subtract ? ~operand : operand;
    assign carryIn   = isArith & carryFlag;
    assign decimalEn = isArith & decimalFlag;
    // tar copies A into the cell, ldr takes the operand
    assign loadData  = (uop == uopTar) ? accum : operand;

    always_comb begin
        case (uop)
            uopAnd:  aluFunc = aluAnd;
            uopEor:  aluFunc = aluEor;
            uopOra:  aluFunc = aluOra;
            uopLsr:  aluFunc = aluLsr;
            default: aluFunc = aluSum;
        endcase
    end

    always_comb begin
        case (uop)
            uopLda:                         resultSel = selOperand;
            uopTra:                         resultSel = selIndexValue;
            uopLdr, uopTar, uopInr, uopDer: resultSel = selIndexNext;
            uopSec, uopClc, uopSed, uopCld: resultSel = selStatus;
            default:                        resultSel = selAlu;
        endcase
    end

    // one strobe per cell, only the addressed cell sees it
    always_comb begin
        logic hit;
        for (int i = 0; i < numIndexRegs; i++) begin
            hit       = opValid && (regSel == regSelE'(i));
            loadEn[i] = hit && ((uop == uopLdr) || (uop == uopTar));
            incEn[i]  = hit && (uop == uopInr);
            decEn[i]  = hit && (uop == uopDer);
        end
    end

    assign opDone   = opValid && (uop != uopNop);
    assign accWrite = opValid && (isArith || isLogic || (uop == uopLda) || (uop == uopTra));
    assign nzUpdate = opValid && (isArith || isLogic || (uop == uopLda) || (uop == uopTra)
                      || (indexWrite && (regSel != regS)));
    // bit 0 enables C, bit 1 enables V, lsr moves C only
    assign cvUpdate = {opValid && isArith, opValid && (isArith || (uop == uopLsr))};

    assign flagSetC = opValid && (uop == uopSec);
    assign flagClrC = opValid && (uop == uopClc);
    assign flagSetD = opValid && (uop == uopSed);
    assign flagClrD = opValid && (uop == uopCld);

endmodule

//--- resultWriteback.sv
// accumulator, status register and the reported result
// result and resultValid appear one cycle after the opDone strobe
// bits 2 and 4 of status read 0 and bit 5 reads 1 at all times
`timescale 1ns/1ns

module resultWriteback import cpuPkg::*; (
    input  logic       phi2,
    input  logic       rstN,
    input  logic       opDone,
    input  logic       accWrite,
    input  resultSelE  resultSel,
    input  logic       nzUpdate,
    input  logic [1:0] cvUpdate,
    input  logic       flagSetC,
    input  logic       flagClrC,
    input  logic       flagSetD,
    input  logic       flagClrD,
    input  logic [7:0] adjusted,
    input  logic       adjCarry,
    input  logic       overflow,
    input  logic [7:0] operand,
    input  logic [7:0] indexValues [numIndexRegs],
    input  logic [7:0] indexNext [numIndexRegs],
    input  regSelE     regSel,
    output logic [7:0] accum,
    output logic [7:0] status,
    output logic [7:0] result,
    output logic       resultValid
);

    logic [7:0] pickedValue;
    logic [7:0] pickedNext;
    logic [7:0] flagStatus;
    logic [7:0] resultByte;
    logic [7:0] statusNext;

    // addressed cell, zero when regSel points at no register
    always_comb begin
        pickedValue = 8'h00;
        pickedNext  = 8'h00;
        for (int i = 0; i < numIndexRegs; i++) begin
            if (regSel == regSelE'(i)) begin
                pickedValue = indexValues[i];
                pickedNext  = indexNext[i];
            end
        end
    end

    // explicit flag ops first, their byte is the reported result
    always_comb begin
        flagStatus = status;
        if (flagSetC) begin
            flagStatus[statusC] = 1'b1;
        end
        if (flagClrC) begin
            flagStatus[statusC] = 1'b0;
        end
        if (flagSetD) begin
            flagStatus[statusD] = 1'b1;
        end
        if (flagClrD) begin
            flagStatus[statusD] = 1'b0;
        end
    end

    always_comb begin
        case (resultSel)
            selOperand:    resultByte = operand;
            selIndexValue: resultByte = pickedValue;
            selIndexNext:  resultByte = pickedNext;
            selStatus:     resultByte = flagStatus;
            default:       resultByte = adjusted;
        endcase
    end

    always_comb begin
        statusNext = flagStatus;
        if (nzUpdate) begin
            statusNext[statusN] = resultByte[7];
            statusNext[statusZ] = (resultByte == 8'h00);
        end
        if (cvUpdate[0]) begin
            statusNext[statusC] = adjCarry;
        end
        if (cvUpdate[1]) begin
            statusNext[statusV] = overflow;
        end
        // I and B unimplemented, bit 5 tied high
        statusNext[2] = 1'b0;
        statusNext[4] = 1'b0;
        statusNext[5] = 1'b1;
    end

    always_ff @(posedge phi2) begin
        if (!rstN) begin
            accum       <= 8'h00;
            status      <= statusResetValue;
            resultValid <= 1'b0;
        end else begin
            if (accWrite) begin
                accum <= resultByte;
            end
            if (opDone) begin
                status <= statusNext;
            end
            resultValid <= opDone;
        end
    end

    // byte of the latest operation, reported with the pulse
    always_ff @(posedge phi2) begin
        if (opDone) begin
            result <= resultByte;
        end
    end

    // an index result needs a cell that exists
    indexSelValid: assert property (
        @(posedge phi2) disable iff (!rstN)
        (opDone && (resultSel inside {selIndexValue, selIndexNext}))
            |-> (int'(regSel) < numIndexRegs)
    ) else $error("resultWriteback: index result from a missing register");

endmodule
